// ==== source/cf_math_pkg.sv ====
/*
 * Math helper package with small constant functions for sizing vectors
 */
package cf_math_pkg;

  // Number of bits needed to address every element of a vector of
  // num_idx entries
  // A vector of one element still needs a one-bit index so that the
  // port carrying it never collapses to zero width
  function automatic integer unsigned idx_width(input integer unsigned num_idx);
    integer unsigned bits;
    // Default for the single-entry case
    bits = 1;
    if (num_idx > 32'd1) begin
      // Ceiling of log2 gives the index width for all larger vectors
      bits = $clog2(num_idx);
    end
    return bits;
  endfunction

endpackage

// ==== source/fp_fmt_pkg.sv ====
/*
 * Binary32 format package with field widths, exponent bias,
 * field types and the rounding-mode encoding
 */
package fp_fmt_pkg;

  // Width of the biased exponent field
  localparam int unsigned EXP_BITS = 8;

  // Width of the stored mantissa field, the hidden one is not counted
  localparam int unsigned MAN_BITS = 23;

  // Exponent bias of single precision
  localparam int unsigned BIAS = 127;

  // Full width of a packed word, sign plus both fields
  localparam int unsigned FP_WIDTH = 1 + EXP_BITS + MAN_BITS;

  // Biased exponent as stored in the word
  typedef logic [EXP_BITS-1:0] exp_t;

  // Stored mantissa bits, the fraction below the hidden one
  typedef logic [MAN_BITS-1:0] man_t;

  // Packed single-precision word
  // Bit 31 is the sign, bits 30 to 23 the exponent and bits 22 to 0 the mantissa
  typedef logic [FP_WIDTH-1:0] fp32_t;

  // Rounding modes of the conversion lane
  // The encoding follows the usual FPU order for the first four modes
  typedef enum logic [1:0] {
    // Round to nearest, ties go to the even mantissa
    RNE = 2'b00,
    // Truncate toward zero
    RTZ = 2'b01,
    // Round toward minus infinity
    RDN = 2'b10,
    // Round toward plus infinity
    RUP = 2'b11
  } rnd_mode_e;

endpackage

// ==== source/lzc.sv ====
/*
 * Leading or trailing zero counter
 * A binary tree of selector nodes returns the index of the first set bit
 */
`timescale 1ns/1ns

module lzc #(
  // Number of input bits to scan
  parameter int unsigned WIDTH     = 2,
  // Set for a leading-zero count, clear for a trailing-zero count
  parameter bit          MODE      = 1'b0,
  // Width of the count, follows from WIDTH and is not meant to be changed
  parameter int unsigned CNT_WIDTH = cf_math_pkg::idx_width(WIDTH)
) (
  input  logic [WIDTH-1:0]     in_i,
  output logic [CNT_WIDTH-1:0] cnt_o,
  output logic                 empty_o
);

  if (WIDTH <= 1) begin : gen_single

    // A single bit either is set or counts as one zero
    assign cnt_o   = CNT_WIDTH'(~in_i[0]);
    assign empty_o = ~in_i[0];

  end else begin : gen_tree

    localparam int unsigned NUM_LEVELS = $clog2(WIDTH);
    // Node 0 is the root, the nodes of level l start at index 2**l - 1
    localparam int unsigned NUM_NODES  = 2 ** NUM_LEVELS - 1;

    // Bit order seen by the tree, always searched from bit 0 upward
    logic [WIDTH-1:0]                     scan;
    // Node has found a set bit somewhere below it
    logic [NUM_NODES-1:0]                 node_vld;
    // Index of the lowest set bit below the node
    logic [NUM_NODES-1:0][NUM_LEVELS-1:0] node_idx;

    if (MODE) begin : gen_flip
      // Leading mode reverses the vector so the top bit becomes index 0
      always_comb begin
        for (int unsigned i = 0; i < WIDTH; i++) begin
          scan[i] = in_i[WIDTH-1-i];
        end
      end
    end else begin : gen_keep
      assign scan = in_i;
    end

    for (genvar lvl = 0; lvl < NUM_LEVELS; lvl++) begin : gen_level
      localparam int unsigned BASE = 2 ** lvl - 1;

      for (genvar n = 0; n < 2 ** lvl; n++) begin : gen_node
        if (lvl == NUM_LEVELS - 1) begin : gen_leaf
          // Leaf nodes look straight at a pair of input bits
          if (2 * n + 1 < WIDTH) begin : gen_pair
            assign node_vld[BASE+n] = scan[2*n] | scan[2*n+1];
            // The lower bit wins when both are set
            assign node_idx[BASE+n] = scan[2*n] ? NUM_LEVELS'(2 * n)
                                                : NUM_LEVELS'(2 * n + 1);
          end else if (2 * n < WIDTH) begin : gen_odd
            // Odd width leaves one bit without a partner
            assign node_vld[BASE+n] = scan[2*n];
            assign node_idx[BASE+n] = NUM_LEVELS'(2 * n);
          end else begin : gen_pad
            // Leaves beyond the input never hold a set bit
            assign node_vld[BASE+n] = 1'b0;
            assign node_idx[BASE+n] = '0;
          end
        end else begin : gen_inner
          // Left child of this node in the next level down
          localparam int unsigned CHILD = 2 ** (lvl + 1) - 1 + 2 * n;

          assign node_vld[BASE+n] = node_vld[CHILD] | node_vld[CHILD+1];
          // Pass up the index of the lower child if it has a set bit
          assign node_idx[BASE+n] = node_vld[CHILD] ? node_idx[CHILD]
                                                    : node_idx[CHILD+1];
        end
      end
    end

    // The root carries the count for the whole vector
    assign cnt_o   = CNT_WIDTH'(node_idx[0]);
    assign empty_o = ~node_vld[0];

  end

endmodule

// ==== source/i2f_normalize.sv ====
/*
 * First stage of the integer to binary32 conversion
 * Takes the magnitude, counts zeros and left-aligns the leading one
 */
`timescale 1ns/1ns

module i2f_normalize #(
  parameter int unsigned INT_WIDTH = 32
) (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        valid_i,
  input  logic                                        signed_i,
  input  logic [INT_WIDTH-1:0]                        int_i,
  input  fp_fmt_pkg::rnd_mode_e                       rnd_mode_i,
  output logic                                        valid_o,
  output logic                                        sign_o,
  output logic                                        zero_o,
  output logic [cf_math_pkg::idx_width(INT_WIDTH)-1:0] exp_o,
  output logic [INT_WIDTH-1:0]                        mant_o,
  output logic [cf_math_pkg::idx_width(INT_WIDTH)-1:0] tz_o,
  output fp_fmt_pkg::rnd_mode_e                       rnd_mode_o
);

  localparam int unsigned CNT_W = cf_math_pkg::idx_width(INT_WIDTH);

  // Bit positions and zero counts inside the operand
  typedef logic [CNT_W-1:0] cnt_t;
  // Unsigned magnitude of the operand
  typedef logic [INT_WIDTH-1:0] mag_t;

  logic neg;
  mag_t mag;
  mag_t mag_norm;
  cnt_t lz_cnt;
  cnt_t tz_cnt;
  cnt_t lead_pos;
  logic mag_empty;

  // Only a signed operand with its top bit set is negative
  assign neg = signed_i & int_i[INT_WIDTH-1];

  // Two's-complement negation gives the magnitude
  // The most negative value maps onto itself, which is the right unsigned magnitude
  assign mag = neg ? mag_t'(-int_i) : int_i;

  // Leading zeros set the normalizing shift
  lzc #(
    .WIDTH (INT_WIDTH),
    .MODE  (1'b1)
  ) lead_cnt_i (
    .in_i    (mag),
    .cnt_o   (lz_cnt),
    .empty_o (mag_empty)
  );

  // Trailing zeros locate the lowest set bit for the sticky decision later on
  // The empty flag is already known from the leading counter
  lzc #(
    .WIDTH (INT_WIDTH),
    .MODE  (1'b0)
  ) trail_cnt_i (
    .in_i    (mag),
    .cnt_o   (tz_cnt),
    .empty_o ()
  );

  // Move the leading one up to the top bit
  assign mag_norm = mag << lz_cnt;

  // Position of the leading one, counted from bit 0
  assign lead_pos = cnt_t'(INT_WIDTH - 1) - lz_cnt;

  // Valid flag of the stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Payload is only captured for an accepted operand
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      sign_o     <= neg;
      zero_o     <= mag_empty;
      exp_o      <= lead_pos;
      mant_o     <= mag_norm;
      tz_o       <= tz_cnt;
      // Mode travels along with its operand
      rnd_mode_o <= rnd_mode_i;
    end
  end

endmodule

// ==== source/i2f_round.sv ====
/*
 * Second stage of the integer to binary32 conversion
 * Rounds the normalized magnitude, packs the word and flags inexact results
 */
`timescale 1ns/1ns

module i2f_round #(
  parameter int unsigned INT_WIDTH = 32
) (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        valid_i,
  input  logic                                        sign_i,
  input  logic                                        zero_i,
  input  logic [cf_math_pkg::idx_width(INT_WIDTH)-1:0] exp_i,
  input  logic [INT_WIDTH-1:0]                        mant_i,
  input  logic [cf_math_pkg::idx_width(INT_WIDTH)-1:0] tz_i,
  input  fp_fmt_pkg::rnd_mode_e                       rnd_mode_i,
  output logic                                        valid_o,
  output fp_fmt_pkg::fp32_t                           result_o,
  output logic                                        inexact_o
);

  // Scratch width with room for the hidden one, the stored bits and the guard bit
  localparam int unsigned MIN_W = fp_fmt_pkg::MAN_BITS + 2;
  localparam int unsigned EXT_W = (INT_WIDTH >= MIN_W) ? INT_WIDTH : MIN_W;

  logic [EXT_W-1:0]      mant_ext;
  fp_fmt_pkg::man_t      man_kept;
  fp_fmt_pkg::man_t      man_rnd;
  fp_fmt_pkg::exp_t      exp_biased;
  fp_fmt_pkg::fp32_t     result_d;
  logic                  guard;
  logic                  sticky;
  logic                  round_up;
  logic                  carry;
  logic                  inexact_d;

  // Narrow operands are padded with zeros below, so the leading one stays on top
  assign mant_ext = EXT_W'(mant_i) << (EXT_W - INT_WIDTH);

  // Stored mantissa is the bits right under the leading one
  assign man_kept = mant_ext[EXT_W-2 -: fp_fmt_pkg::MAN_BITS];

  // First discarded bit
  assign guard = mant_ext[EXT_W-2-fp_fmt_pkg::MAN_BITS];

  // The guard bit sits at position exp - 24 of the magnitude
  // Any set bit below it means the lowest set bit lies under that position
  assign sticky = (32'(tz_i) + 32'(fp_fmt_pkg::MAN_BITS + 1)) < 32'(exp_i);

  // Round-up decision per mode
  always_comb begin
    round_up = 1'b0;
    case (rnd_mode_i)
      fp_fmt_pkg::RNE: round_up = guard & (sticky | man_kept[0]);
      fp_fmt_pkg::RUP: round_up = ~sign_i & (guard | sticky);
      fp_fmt_pkg::RDN: round_up = sign_i & (guard | sticky);
      fp_fmt_pkg::RTZ: round_up = 1'b0;
      default:         round_up = 1'b0;
    endcase
  end

  // Increment the mantissa, a carry out leaves it all zero
  assign {carry, man_rnd} = {1'b0, man_kept} + {{fp_fmt_pkg::MAN_BITS{1'b0}}, round_up};

  // Bias the leading-one position and take in the carry from rounding
  assign exp_biased = fp_fmt_pkg::exp_t'(exp_i)
                    + fp_fmt_pkg::exp_t'(fp_fmt_pkg::BIAS)
                    + fp_fmt_pkg::exp_t'(carry);

  // Zero has no leading one and packs as positive zero
  assign result_d = zero_i ? '0 : {sign_i, exp_biased, man_rnd};

  // Any discarded set bit makes the result inexact
  assign inexact_d = ~zero_i & (guard | sticky);

  // Valid flag of the stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Result registers load together with their valid
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o  <= result_d;
      inexact_o <= inexact_d;
    end
  end

endmodule

// ==== source/i2f_conv_top.sv ====
/*
 * Integer to binary32 conversion lane
 * Two-stage pipeline of normalization and rounding
 */
`timescale 1ns/1ns

module i2f_conv_top #(
  parameter int unsigned INT_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  valid_i,
  input  logic                  signed_i,
  input  logic [INT_WIDTH-1:0]  int_i,
  input  fp_fmt_pkg::rnd_mode_e rnd_mode_i,
  output logic                  valid_o,
  output fp_fmt_pkg::fp32_t     result_o,
  output logic                  inexact_o
);

  localparam int unsigned CNT_W = cf_math_pkg::idx_width(INT_WIDTH);

  // Stage 1 to stage 2 signals
  logic                  s1_valid;
  logic                  s1_sign;
  logic                  s1_zero;
  logic [CNT_W-1:0]      s1_exp;
  logic [INT_WIDTH-1:0]  s1_mant;
  logic [CNT_W-1:0]      s1_tz;
  fp_fmt_pkg::rnd_mode_e s1_rnd;

  i2f_normalize #(
    .INT_WIDTH (INT_WIDTH)
  ) normalize_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .valid_i    (valid_i),
    .signed_i   (signed_i),
    .int_i      (int_i),
    .rnd_mode_i (rnd_mode_i),
    .valid_o    (s1_valid),
    .sign_o     (s1_sign),
    .zero_o     (s1_zero),
    .exp_o      (s1_exp),
    .mant_o     (s1_mant),
    .tz_o       (s1_tz),
    .rnd_mode_o (s1_rnd)
  );

  i2f_round #(
    .INT_WIDTH (INT_WIDTH)
  ) round_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .valid_i    (s1_valid),
    .sign_i     (s1_sign),
    .zero_i     (s1_zero),
    .exp_i      (s1_exp),
    .mant_i     (s1_mant),
    .tz_i       (s1_tz),
    .rnd_mode_i (s1_rnd),
    .valid_o    (valid_o),
    .result_o   (result_o),
    .inexact_o  (inexact_o)
  );

endmodule

// ==== sim/tb_clock_gen.sv ====
/*
 * Testbench clock and reset generator
 */
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int unsigned PERIOD     = 8,
  parameter int unsigned RST_CYCLES = 10
) (
  output logic clk_o,
  output logic reset_o
);

  // Free-running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset covers the first rising edges and drops on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

// ==== sim/i2f_conv_tb.sv ====
/*
 * Directed testbench of the integer to binary32 conversion lane
 * Compares every result against a bit-level conversion model
 */
`timescale 1ns/1ns

module i2f_conv_tb;

  localparam int unsigned INT_WIDTH = 32;
  localparam int          TIMEOUT   = 20;
  localparam int          NUM_RAND  = 200;

  logic                  clk;
  logic                  reset;
  logic                  valid_i;
  logic                  signed_i;
  logic [INT_WIDTH-1:0]  int_i;
  fp_fmt_pkg::rnd_mode_e rnd_mode_i;
  logic                  valid_o;
  fp_fmt_pkg::fp32_t     result_o;
  logic                  inexact_o;

  // Inexact flag seen by the last single conversion
  logic                  last_inexact;
  logic [31:0]           rng_state;

  tb_clock_gen #(
    .PERIOD     (8),
    .RST_CYCLES (10)
  ) clock_gen_i (
    .clk_o   (clk),
    .reset_o (reset)
  );

  i2f_conv_top #(
    .INT_WIDTH (INT_WIDTH)
  ) dut_i (
    .clk_i      (clk),
    .reset_i    (reset),
    .valid_i    (valid_i),
    .signed_i   (signed_i),
    .int_i      (int_i),
    .rnd_mode_i (rnd_mode_i),
    .valid_o    (valid_o),
    .result_o   (result_o),
    .inexact_o  (inexact_o)
  );

  // Every failure ends up here
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input fp_fmt_pkg::fp32_t got, input fp_fmt_pkg::fp32_t want,
                            input string ctx);
    if (got !== want) begin
      fail_now($sformatf("CHECK FAILED result_o: got %h expected %h (%s)", got, want, ctx));
    end
  endtask

  task automatic check_bit(input logic got, input logic want, input string name,
                           input string ctx);
    if (got !== want) begin
      fail_now($sformatf("CHECK FAILED %s: got %h expected %h (%s)", name, got, want, ctx));
    end
  endtask

  // Xorshift generator with 32-bit state
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Conversion model working straight on the integer bits
  function automatic void ref_convert(input logic [31:0] val, input logic sgn,
                                      input fp_fmt_pkg::rnd_mode_e mode,
                                      output fp_fmt_pkg::fp32_t word, output logic inexact);
    logic             neg;
    logic [31:0]      mag;
    logic [63:0]      mask;
    fp_fmt_pkg::man_t kept;
    logic [23:0]      sum;
    logic             guard;
    logic             sticky;
    logic             up;
    int               pos;
    int               shift;
    neg = sgn & val[31];
    mag = neg ? (~val + 32'd1) : val;
    pos = -1;
    // Scan upward so the highest set bit is the last one seen
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) pos = i;
    end
    if (pos < 0) begin
      word    = '0;
      inexact = 1'b0;
      return;
    end
    guard  = 1'b0;
    sticky = 1'b0;
    if (pos <= 23) begin
      kept = fp_fmt_pkg::man_t'(mag << (23 - pos));
    end else begin
      shift  = pos - 23;
      kept   = fp_fmt_pkg::man_t'(mag >> shift);
      guard  = mag[shift-1];
      // Everything under the guard bit feeds sticky
      mask   = (64'd1 << (shift - 1)) - 64'd1;
      sticky = |({32'd0, mag} & mask);
    end
    case (mode)
      fp_fmt_pkg::RNE: up = guard & (sticky | kept[0]);
      fp_fmt_pkg::RUP: up = ~neg & (guard | sticky);
      fp_fmt_pkg::RDN: up = neg & (guard | sticky);
      default:         up = 1'b0;
    endcase
    sum     = {1'b0, kept} + {23'd0, up};
    word    = {neg, fp_fmt_pkg::exp_t'(pos + 127 + int'(sum[23])), sum[22:0]};
    inexact = guard | sticky;
  endfunction

  // One operand through the pipeline and a wait for its result
  task automatic run_one(input logic [31:0] val, input logic sgn,
                         input fp_fmt_pkg::rnd_mode_e mode);
    fp_fmt_pkg::fp32_t want_word;
    logic              want_inex;
    int                cycles;
    string             ctx;
    ref_convert(val, sgn, mode, want_word, want_inex);
    ctx = $sformatf("int %h signed %0d mode %s", val, sgn, mode.name());
    @(negedge clk);
    valid_i    = 1'b1;
    int_i      = val;
    signed_i   = sgn;
    rnd_mode_i = mode;
    @(negedge clk);
    valid_i = 1'b0;
    cycles  = 1;
    while (valid_o !== 1'b1) begin
      if (cycles >= TIMEOUT) fail_now($sformatf("No valid_o for operand %s", ctx));
      @(negedge clk);
      cycles++;
    end
    if (cycles != 2) begin
      fail_now($sformatf("Result came %0d cycles after its operand instead of 2 (%s)",
                         cycles, ctx));
    end
    check_word(result_o, want_word, ctx);
    check_bit(inexact_o, want_inex, "inexact_o", ctx);
    last_inexact = inexact_o;
  endtask

  // Valid must stay low through reset and while nothing is sent
  task automatic test_reset_valid();
    int cycles;
    cycles = 0;
    // The first rising edge under reset clears both valid registers
    @(posedge clk);
    @(negedge clk);
    while (reset === 1'b1) begin
      check_bit(valid_o, 1'b0, "valid_o", "during reset");
      if (cycles >= TIMEOUT) fail_now("Reset was never released");
      @(negedge clk);
      cycles++;
    end
    repeat (5) begin
      check_bit(valid_o, 1'b0, "valid_o", "after reset");
      @(negedge clk);
    end
  endtask

  task automatic test_exact();
    logic [31:0] vals [9];
    vals = '{32'd0, 32'd1, 32'hFFFFFFFF, 32'd12345, 32'h00FFFFFF, 32'h00800001,
             32'h00ABCDEF, 32'hFF000000, 32'h00001000};
    for (int m = 0; m < 4; m++) begin
      for (int i = 0; i < 9; i++) begin
        // All of these fit in 24 bits of magnitude when read as signed
        run_one(vals[i], 1'b1, fp_fmt_pkg::rnd_mode_e'(m));
        check_bit(last_inexact, 1'b0, "inexact_o", "exact operand");
      end
      // Every power of two up to the top bit is exact when read as unsigned
      for (int b = 0; b < 32; b++) begin
        run_one(32'd1 << b, 1'b0, fp_fmt_pkg::rnd_mode_e'(m));
        check_bit(last_inexact, 1'b0, "inexact_o", "power of two");
      end
    end
  endtask

  // One operand for each leading-one position with a pattern underneath
  task automatic test_normalize();
    logic [31:0] val;
    for (int b = 0; b < 32; b++) begin
      val = (32'd1 << b) | (32'h5A5A5A5A & ((32'd1 << b) - 32'd1));
      run_one(val, 1'b0, fp_fmt_pkg::RNE);
      run_one(val, 1'b0, fp_fmt_pkg::RUP);
    end
  endtask

  task automatic test_rounding();
    logic [31:0] cases [7];
    // Tie to even, tie rounding up, sticky only, guard and sticky, carries
    cases = '{32'h01000001, 32'h01000003, 32'h02000001, 32'h02000003,
              32'h01FFFFFF, 32'h7FFFFFC0, 32'h12345678};
    for (int m = 0; m < 4; m++) begin
      for (int i = 0; i < 7; i++) begin
        run_one(cases[i], 1'b0, fp_fmt_pkg::rnd_mode_e'(m));
        run_one(~cases[i] + 32'd1, 1'b1, fp_fmt_pkg::rnd_mode_e'(m));
      end
      // Largest unsigned value rounds into the next exponent
      run_one(32'hFFFFFFFF, 1'b0, fp_fmt_pkg::rnd_mode_e'(m));
    end
  endtask

  task automatic test_signedness();
    logic [31:0] pats [6];
    pats = '{32'h80000000, 32'hFFFFFFFF, 32'h80000001, 32'hC0000000,
             32'h7FFFFFFF, 32'hFF000001};
    for (int m = 0; m < 4; m++) begin
      for (int i = 0; i < 6; i++) begin
        run_one(pats[i], 1'b0, fp_fmt_pkg::rnd_mode_e'(m));
        run_one(pats[i], 1'b1, fp_fmt_pkg::rnd_mode_e'(m));
      end
    end
  endtask

  // Back-to-back operands with each result expected two falling edges later
  task automatic test_throughput();
    fp_fmt_pkg::fp32_t want_word [NUM_RAND];
    logic              want_inex [NUM_RAND];
    logic [31:0]       ctl;
    string             ctx;
    for (int k = 0; k < NUM_RAND + 2; k++) begin
      @(negedge clk);
      if (k >= 2) begin
        ctx = $sformatf("random operand %0d", k - 2);
        check_bit(valid_o, 1'b1, "valid_o", ctx);
        check_word(result_o, want_word[k-2], ctx);
        check_bit(inexact_o, want_inex[k-2], "inexact_o", ctx);
      end
      if (k < NUM_RAND) begin
        rng_state = xorshift(rng_state);
        ctl       = rng_state;
        rng_state = xorshift(rng_state);
        // Right shift spreads the leading one over all positions
        int_i      = rng_state >> ctl[7:3];
        signed_i   = ctl[2];
        rnd_mode_i = fp_fmt_pkg::rnd_mode_e'(ctl[1:0]);
        valid_i    = 1'b1;
        ref_convert(int_i, signed_i, rnd_mode_i, want_word[k], want_inex[k]);
      end else begin
        valid_i = 1'b0;
      end
    end
    @(negedge clk);
    check_bit(valid_o, 1'b0, "valid_o", "after the random burst");
  endtask

  initial begin
    valid_i      = 1'b0;
    signed_i     = 1'b0;
    int_i        = '0;
    rnd_mode_i   = fp_fmt_pkg::RNE;
    last_inexact = 1'b0;
    rng_state    = 32'h9fae;
    test_reset_valid();
    test_exact();
    test_normalize();
    test_rounding();
    test_signedness();
    test_throughput();
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== files.f ====
source/cf_math_pkg.sv
source/fp_fmt_pkg.sv
source/lzc.sv
source/i2f_normalize.sv
source/i2f_round.sv
source/i2f_conv_top.sv
sim/tb_clock_gen.sv
sim/i2f_conv_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the conversion lane testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

# A failed build or a crashed run also counts as a failed test
{ verilator --binary --timing -f files.f --top-module i2f_conv_tb \
    -Mdir obj_dir -o i2f_conv_sim && ./obj_dir/i2f_conv_sim; } > sim.log 2>&1 \
  || echo "Testbench failed" >> sim.log

cat sim.log

grep -q "Testbench failed" sim.log && { echo "Simulation FAILED"; exit 1; }
echo "Simulation PASSED"
exit 0
